// File: Makefile
# Verilator build and run for the CRC-32 hub.

VERILATOR ?= verilator
TOP       ?= crc_hub_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/crc_hub_assert.sv
`timescale 1ns/1ps
`default_nettype none

module crc_hub_assert
    import crc_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst_n,
    input wire byte_beat_t   in_beat,
    input wire lane_cmd_t    lane_cmd    [num_lanes],
    input wire lane_result_t lane_result [num_lanes],
    input wire logic         result_valid,
    input wire logic         drop
);

    logic [num_lanes-1:0] done_vec;
    logic [num_lanes-1:0] en_vec;
    logic                 drop_tail;    // later bytes of a dropped frame in flight.

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            done_vec[i] = lane_result[i].done;
            en_vec[i]   = lane_cmd[i].en;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_tail <= 1'b0;
        end else begin
            drop_tail <= in_beat.en && (drop || drop_tail);
        end
    end

    // lanes finish one at a time.
    one_done_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(done_vec))
        else $error("more than one lane raised done in the same cycle");

    valid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid stayed high for more than one cycle");

    // no byte of a dropped frame reaches a lane.
    drop_no_en_a: assert property (@(posedge clk) disable iff (!rst_n)
        (drop || drop_tail) |-> (en_vec == '0))
        else $error("a lane enable was high during a dropped frame");

endmodule

bind crc_hub crc_hub_assert crc_hub_assert_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_beat      (in_beat),
    .lane_cmd     (lane_cmd),
    .lane_result  (lane_result),
    .result_valid (result_valid),
    .drop         (drop)
);

`default_nettype wire

// File: bench/crc_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module crc_hub_tb
    import crc_pkg::*;
();

    typedef logic [7:0] byte_q_t [$];

    typedef struct packed {
        logic [frame_id_w-1:0] id;
        logic [31:0]           crc;
        logic [31:0]           last_edge;    // edge that sampled the last byte.
    } expect_t;

    localparam int unsigned latency     = 11;
    localparam int unsigned drain_limit = 600;

    logic                  clk;
    logic                  rst_n;
    byte_beat_t            in_beat;
    logic                  result_valid;
    logic [31:0]           result_crc;
    logic [frame_id_w-1:0] result_id;
    logic                  drop;
    logic                  lanes_busy;

    expect_t     expect_q [$];
    int unsigned drop_q [$];    // cycle in which each drop is due.
    int unsigned cycle_cnt    = 0;
    int unsigned accepted     = 0;
    int unsigned dropped      = 0;
    int unsigned results_seen = 0;
    int unsigned drops_seen   = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    crc_hub crc_hub_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_beat      (in_beat),
        .result_valid (result_valid),
        .result_crc   (result_crc),
        .result_id    (result_id),
        .drop         (drop),
        .lanes_busy   (lanes_busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // crc-32, msb-first register, each byte fed lsb first.
    function automatic logic [31:0] crc_ref(input byte_q_t bytes);
        logic [31:0] c;
        c = 32'hffff_ffff;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (c[31] != bytes[i][b]) begin
                    c = (c << 1) ^ 32'h04c1_1db7;
                end else begin
                    c = c << 1;
                end
            end
        end
        return c;
    endfunction

    // a lane stays taken until the edge after its result leaves.
    function automatic int unsigned lanes_in_use();
        int unsigned n;
        n = 0;
        foreach (expect_q[k]) begin
            if (expect_q[k].last_edge + latency > cycle_cnt) begin
                n++;
            end
        end
        return n;
    endfunction

    initial begin : compare_results
        expect_t e;
        forever begin
            @(negedge clk);
            if (rst_n && result_valid) begin
                if (expect_q.size() == 0) begin
                    $display("result_valid pulsed with no frame outstanding at %0t ns", $time);
                    abort_run();
                end else begin
                    e = expect_q.pop_front();
                    check_eq(32'(result_id), 32'(e.id), "result_id");
                    check_eq(result_crc, e.crc, "result_crc");
                    check_eq(cycle_cnt - e.last_edge, latency, "result latency in cycles");
                    results_seen++;
                end
            end
            if (rst_n && drop) begin
                if (drop_q.size() == 0) begin
                    $display("drop pulsed for a frame that had an idle lane at %0t ns", $time);
                    abort_run();
                end else begin
                    check_eq(cycle_cnt, drop_q.pop_front(), "drop cycle");
                    drops_seen++;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_frame(input int len, input bit zeros, input int gap);
        byte_q_t bytes;
        expect_t e;
        bit      busy;
        busy = 1'b0;
        for (int i = 0; i < len; i++) begin
            bytes.push_back(zeros ? 8'h00 : 8'($urandom));
        end
        foreach (bytes[i]) begin
            @(posedge clk);
            in_beat.en   <= 1'b1;
            in_beat.data <= bytes[i];
            @(negedge clk);
            if (i == 0) begin
                check_eq(32'(lanes_busy), 32'(lanes_in_use() >= num_lanes),
                         "lanes_busy at frame start");
                busy = lanes_busy;    // what dispatch sees at the next edge.
                if (busy) begin
                    drop_q.push_back(cycle_cnt + 1);
                end
            end
        end
        e.last_edge = cycle_cnt + 1;
        if (busy) begin
            dropped++;
        end else begin
            e.id  = frame_id_w'(accepted);
            e.crc = crc_ref(bytes);
            expect_q.push_back(e);
            accepted++;
        end
        for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            in_beat.en   <= 1'b0;
            in_beat.data <= 8'($urandom);    // noise between frames.
        end
    endtask

    task automatic quiet_check(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_eq(32'(result_valid), 32'h0, "result_valid while idle");
            check_eq(32'(drop), 32'h0, "drop while idle");
            check_eq(32'(lanes_busy), 32'h0, "lanes_busy while idle");
        end
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (expect_q.size() != 0 || drop_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                $display("timeout: %0d results and %0d drops still missing after %0d cycles",
                         expect_q.size(), drop_q.size(), limit);
                abort_run();
            end
        end
    endtask

    initial begin : run_test
        int len;
        int gap;
        void'($urandom(32'he64864bf));
        rst_n   <= 1'b0;
        in_beat <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        quiet_check(30);

        // isolated frames, one lane at a time.
        send_frame(1, 1'b0, 16);
        send_frame(12, 1'b1, 16);
        for (int n = 0; n < 6; n++) begin
            len = 1 + int'($urandom % 24);
            send_frame(len, 1'b0, 16);
        end
        wait_drained(drain_limit);

        // short frames back to back overlap in several lanes.
        for (int n = 0; n < 12; n++) begin
            len = 1 + int'($urandom % 4);
            send_frame(len, 1'b0, 1);
        end
        wait_drained(drain_limit);

        // one-byte burst outruns the lanes.
        for (int n = 0; n < 16; n++) begin
            send_frame(1, 1'b0, 1);
        end
        wait_drained(drain_limit);
        check_eq(32'(dropped != 0), 32'h1, "frames dropped by the burst");

        // random mix of lengths and gaps.
        for (int n = 0; n < 40; n++) begin
            len = 1 + int'($urandom % 24);
            gap = 1 + int'($urandom % 8);
            send_frame(len, 1'b0, gap);
        end
        wait_drained(drain_limit);
        quiet_check(20);

        if (results_seen == accepted && drops_seen == dropped) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d results and %0d drops seen where %0d and %0d were due",
                     results_seen, drops_seen, accepted, dropped);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: source/crc_hub.sv
`timescale 1ns/1ps
`default_nettype none

module crc_hub
    import crc_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire byte_beat_t       in_beat,
    output logic                  result_valid,
    output logic [31:0]           result_crc,
    output logic [frame_id_w-1:0] result_id,
    output logic                  drop,
    output logic                  lanes_busy
);

    lane_cmd_t            lane_cmd    [num_lanes];
    lane_result_t         lane_result [num_lanes];
    logic [num_lanes-1:0] lane_idle;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // front end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    frame_dispatch frame_dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .lane_idle  (lane_idle),
        .lane_cmd   (lane_cmd),
        .drop       (drop),
        .lanes_busy (lanes_busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // crc lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        crc_lane crc_lane_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .cmd    (lane_cmd[g]),
            .idle   (lane_idle[g]),
            .result (lane_result[g])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // back end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    result_collect result_collect_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_result  (lane_result),
        .result_valid (result_valid),
        .result_crc   (result_crc),
        .result_id    (result_id)
    );

endmodule

`default_nettype wire

// File: source/crc_lane.sv
`timescale 1ns/1ps
`default_nettype none

module crc_lane
    import crc_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire lane_cmd_t cmd,
    output logic           idle,
    output lane_result_t   result
);

    logic [1:0]              state;
    logic [settle_cnt_w-1:0] settle_cnt;
    logic [31:0]             crc_q;
    logic [31:0]             crc_step;
    logic [frame_id_w-1:0]   id_q;
    logic                    absorbing;

    // one byte through the register, bit 0 first.
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [7:0]  data);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int b = 0; b < 8; b++) begin
            fb = c[31] ^ data[b];
            c  = {c[30:0], 1'b0} ^ (fb ? crc_poly : 32'h0);
        end
        return c;
    endfunction

    assign crc_step  = crc_byte(crc_q, cmd.data);    // unrolls to the xor network.
    assign absorbing = cmd.en && (state == lst_idle || state == lst_absorb);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= lst_idle;
            settle_cnt <= '0;
        end else begin
            case (state)
                lst_idle: begin
                    if (cmd.en) begin
                        state <= lst_absorb;
                    end
                end
                lst_absorb: begin
                    if (!cmd.en) begin    // frame over.
                        state      <= lst_settle;
                        settle_cnt <= '0;
                    end
                end
                lst_settle: begin
                    if (settle_cnt == settle_last) begin
                        state <= lst_done;
                    end
                    settle_cnt <= settle_cnt + settle_cnt_w'(1);
                end
                lst_done: begin
                    state <= lst_idle;
                end
                default: begin
                    state <= lst_idle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (absorbing) begin
            crc_q <= crc_step;
        end else if (state == lst_idle) begin
            crc_q <= crc_init;    // seed for the next frame.
        end
        if (cmd.en && state == lst_idle) begin
            id_q <= cmd.frame_id;
        end
    end

    assign idle = (state == lst_idle);

    always_comb begin
        result.done     = (state == lst_done);
        result.crc      = crc_q;
        result.frame_id = id_q;
    end

endmodule

`default_nettype wire

// File: source/crc_pkg.sv
`default_nettype none

package crc_pkg;

    localparam int unsigned num_lanes     = 4;
    localparam int unsigned lane_idx_w    = 2;
    localparam int unsigned frame_id_w    = 8;
    localparam int unsigned settle_cycles = 8;
    localparam int unsigned settle_cnt_w  = $clog2(settle_cycles);

    localparam logic [31:0] crc_init = 32'hffff_ffff;
    localparam logic [31:0] crc_poly = 32'h04c1_1db7;    // crc-32, left shifting.

    localparam logic [settle_cnt_w-1:0] settle_last = settle_cnt_w'(settle_cycles - 1);

    // lane fsm encodings.
    localparam logic [1:0] lst_idle   = 2'd0;
    localparam logic [1:0] lst_absorb = 2'd1;
    localparam logic [1:0] lst_settle = 2'd2;
    localparam logic [1:0] lst_done   = 2'd3;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } byte_beat_t;

    typedef struct packed {
        logic                  en;
        logic [7:0]            data;
        logic [frame_id_w-1:0] frame_id;
    } lane_cmd_t;

    typedef struct packed {
        logic                  done;
        logic [31:0]           crc;
        logic [frame_id_w-1:0] frame_id;
    } lane_result_t;

endpackage

`default_nettype wire

// File: source/frame_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module frame_dispatch
    import crc_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire byte_beat_t           in_beat,
    input  wire logic [num_lanes-1:0] lane_idle,
    output lane_cmd_t                 lane_cmd [num_lanes],
    output logic                      drop,
    output logic                      lanes_busy
);

    logic                  en_q;    // last cycle's en.
    logic [7:0]            data_q;
    logic                  frame_start;
    logic                  pick_found;
    logic [lane_idx_w-1:0] pick_lane;
    logic [lane_idx_w-1:0] ptr;
    logic [lane_idx_w-1:0] cur_lane;
    logic                  cur_ok;    // current frame owns a lane.
    logic [frame_id_w-1:0] cur_id;
    logic [frame_id_w-1:0] next_id;

    assign frame_start = in_beat.en && !en_q;
    assign lanes_busy  = ~|lane_idle;

    // first idle lane at or after the pointer.
    always_comb begin
        logic [lane_idx_w-1:0] idx;
        pick_found = 1'b0;
        pick_lane  = ptr;
        for (int k = 0; k < num_lanes; k++) begin
            idx = ptr + lane_idx_w'(k);
            if (!pick_found && lane_idle[idx]) begin
                pick_found = 1'b1;
                pick_lane  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q    <= 1'b0;
            cur_ok  <= 1'b0;
            ptr     <= '0;
            next_id <= '0;
            drop    <= 1'b0;
        end else begin
            en_q <= in_beat.en;
            drop <= frame_start && !pick_found;
            if (frame_start) begin
                cur_ok <= pick_found;
                if (pick_found) begin
                    ptr     <= pick_lane + lane_idx_w'(1);
                    next_id <= next_id + frame_id_w'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= in_beat.data;
        if (frame_start && pick_found) begin
            cur_lane <= pick_lane;    // held for the whole frame.
            cur_id   <= next_id;
        end
    end

    // only the owning lane sees en, one cycle behind the input.
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_cmd[i].en       = en_q && cur_ok && (cur_lane == lane_idx_w'(i));
            lane_cmd[i].data     = data_q;
            lane_cmd[i].frame_id = cur_id;
        end
    end

endmodule

`default_nettype wire

// File: source/result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module result_collect
    import crc_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire lane_result_t lane_result [num_lanes],
    output logic              result_valid,
    output logic [31:0]       result_crc,
    output logic [frame_id_w-1:0] result_id
);

    logic                  any_done;
    logic [lane_idx_w-1:0] sel_idx;

    // at most one lane finishes per cycle.
    always_comb begin
        any_done = 1'b0;
        sel_idx  = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_result[i].done) begin
                any_done = 1'b1;
                sel_idx  = lane_idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= any_done;
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            result_crc <= lane_result[sel_idx].crc;
            result_id  <= lane_result[sel_idx].frame_id;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
source/crc_pkg.sv
source/crc_lane.sv
source/frame_dispatch.sv
source/result_collect.sv
source/crc_hub.sv
bench/crc_hub_assert.sv
bench/crc_hub_tb.sv
